/* flist.f */
+incdir+include
hw/trace_pkg.sv
hw/trace_ram.sv
hw/trace_capture.sv
hw/trace_dump_seq.sv
hw/uart_tx.sv
hw/trace_top.sv
testbench/trace_props.sv
testbench/trace_tb.sv

/* hw/trace_capture.sv */
/*
 * Capture control for the trace ring
 * Writes each strobed word at the write pointer until the trigger
 * On trigger it freezes and hands the oldest address and entry count
 * to the dump sequencer with a one-cycle dump_start pulse
 */

`include "trace_cfg.svh"

module trace_capture import trace_pkg::*; (
	input clk,
	input reset,
	input [`TRACE_WIDTH_BITS-1:0] capture_data,
	input capture_enable,
	input trigger,
	output logic wr_enable,
	output logic [$clog2(`TRACE_DEPTH)-1:0] wr_addr,
	output logic [`TRACE_WIDTH_BITS-1:0] wr_data,
	output logic dump_start,
	output logic [$clog2(`TRACE_DEPTH)-1:0] oldest_addr,
	output logic [$clog2(`TRACE_DEPTH):0] entry_count
);

	localparam int ADDR_WIDTH = $clog2(`TRACE_DEPTH);
	localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

	capture_state_t state;
	logic [ADDR_WIDTH-1:0] write_ptr;
	logic wrapped;
	logic [ADDR_WIDTH-1:0] next_ptr;
	logic next_wrapped;

	// Strobe goes straight to the RAM, also in the trigger cycle
	assign wr_enable = (state == CAPTURING) && capture_enable;
	assign wr_addr = write_ptr;
	assign wr_data = capture_data;

	// Pointer and wrap flag after this cycle's write
	// Used on trigger so a word strobed with the trigger counts
	always_comb
	begin
		next_ptr = write_ptr;
		next_wrapped = wrapped;
		if (wr_enable)
		begin
			next_ptr = write_ptr + 1'b1;
			// Last slot written, ring is full from here on
			if (write_ptr == ADDR_WIDTH'(`TRACE_DEPTH - 1))
				next_wrapped = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= CAPTURING;
			write_ptr <= '0;
			wrapped <= 1'b0;
			dump_start <= 1'b0;
			oldest_addr <= '0;
			entry_count <= '0;
		end
		else
		begin
			dump_start <= 1'b0;
			if (state == CAPTURING)
			begin
				write_ptr <= next_ptr;
				wrapped <= next_wrapped;
				if (trigger)
				begin
					state <= FROZEN;
					dump_start <= 1'b1;
					if (next_wrapped)
					begin
						// Full ring, oldest word sits at the next write slot
						oldest_addr <= next_ptr;
						entry_count <= COUNT_WIDTH'(`TRACE_DEPTH);
					end
					else
					begin
						// Partial fill starts at slot zero
						oldest_addr <= '0;
						entry_count <= {1'b0, next_ptr};
					end
				end
			end
			// FROZEN holds everything until reset
		end
	end

endmodule

/* hw/trace_dump_seq.sv */
/*
 * Dump sequencer
 * Reads the kept entries oldest first and hands each word to the
 * transmitter one byte at a time, least significant byte first
 * dump_done stays high after the last frame until reset
 */

`include "trace_cfg.svh"

module trace_dump_seq import trace_pkg::*; (
	input clk,
	input reset,
	input dump_start,
	input [$clog2(`TRACE_DEPTH)-1:0] oldest_addr,
	input [$clog2(`TRACE_DEPTH):0] entry_count,
	output logic [$clog2(`TRACE_DEPTH)-1:0] rd_addr,
	input [`TRACE_WIDTH_BITS-1:0] rd_data,
	input tx_ready,
	output logic tx_start,
	output logic [7:0] tx_byte,
	output logic dump_done
);

	localparam int ADDR_WIDTH = $clog2(`TRACE_DEPTH);
	localparam int COUNT_WIDTH = ADDR_WIDTH + 1;
	localparam int WORD_BYTES = (`TRACE_WIDTH_BITS + 7) / 8;
	localparam int BYTE_INDEX_WIDTH = (WORD_BYTES > 1) ? $clog2(WORD_BYTES) : 1;

	dump_state_t state;
	logic [COUNT_WIDTH-1:0] entries_left;
	logic [BYTE_INDEX_WIDTH-1:0] byte_index;
	logic [`TRACE_WIDTH_BITS-1:0] word_latch;
	logic [WORD_BYTES*8-1:0] current_word;
	logic frame_clear;

	// First byte of a word comes straight from the RAM output
	// later bytes from the latched copy
	assign current_word = (WORD_BYTES*8)'((byte_index == '0) ? rd_data : word_latch);

	// tx_ready only drops the cycle after tx_start, so ignore it
	// while our own strobe is still out
	assign frame_clear = tx_ready && !tx_start;

	assign dump_done = (state == DUMP_DONE);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= DUMP_IDLE;
			entries_left <= '0;
			byte_index <= '0;
			rd_addr <= '0;
			tx_start <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				DUMP_IDLE:
				begin
					if (dump_start)
					begin
						rd_addr <= oldest_addr;
						entries_left <= entry_count;
						byte_index <= '0;
						// Nothing captured, finish without a frame
						if (entry_count == '0)
							state <= DUMP_DONE;
						else
							state <= DUMP_READ;
					end
				end

				// One cycle of RAM read latency
				DUMP_READ:
					state <= DUMP_SEND;

				DUMP_SEND:
				begin
					if (tx_ready)
					begin
						tx_start <= 1'b1;
						if (byte_index == BYTE_INDEX_WIDTH'(WORD_BYTES - 1))
							byte_index <= '0;
						else
							byte_index <= byte_index + 1'b1;
						state <= DUMP_WAIT;
					end
				end

				DUMP_WAIT:
				begin
					if (frame_clear)
					begin
						// byte_index back at zero means the word is finished
						if (byte_index != '0)
							state <= DUMP_SEND;
						else if (entries_left == COUNT_WIDTH'(1))
							state <= DUMP_DONE;
						else
						begin
							entries_left <= entries_left - 1'b1;
							// Power-of-two depth, address wraps on its own
							rd_addr <= rd_addr + 1'b1;
							state <= DUMP_READ;
						end
					end
				end

				// Stopped until reset
				DUMP_DONE:
					state <= DUMP_DONE;

				default:
					state <= DUMP_IDLE;
			endcase
		end
	end

	// Word copy and outgoing byte
	always_ff @(posedge clk)
	begin
		if (state == DUMP_SEND && tx_ready)
		begin
			if (byte_index == '0)
				word_latch <= rd_data;
			tx_byte <= current_word[byte_index * 8 +: 8];
		end
	end

endmodule

/* hw/trace_pkg.sv */
/*
 * State types shared by the trace buffer blocks
 * Import with a wildcard in the module header where a state type is used
 */

package trace_pkg;

	// Capture side, writes are allowed only while capturing
	typedef enum logic [0:0]
	{
		CAPTURING = 1'b0,
		FROZEN    = 1'b1
	} capture_state_t;

	// Dump sequencer
	typedef enum logic [2:0]
	{
		DUMP_IDLE = 3'd0,
		DUMP_READ = 3'd1,
		DUMP_SEND = 3'd2,
		DUMP_WAIT = 3'd3,
		DUMP_DONE = 3'd4
	} dump_state_t;

	// Serial transmitter, one state per part of the frame
	typedef enum logic [1:0]
	{
		UART_IDLE  = 2'd0,
		UART_START = 2'd1,
		UART_DATA  = 2'd2,
		UART_STOP  = 2'd3
	} uart_state_t;

endpackage

/* hw/trace_ram.sv */
/*
 * Ring storage for captured words
 * One write port and one read port with a registered output
 * Read data is valid one cycle after the address is presented
 */

`include "trace_cfg.svh"

module trace_ram (
	input clk,
	input wr_enable,
	input [$clog2(`TRACE_DEPTH)-1:0] wr_addr,
	input [`TRACE_WIDTH_BITS-1:0] wr_data,
	input [$clog2(`TRACE_DEPTH)-1:0] rd_addr,
	output logic [`TRACE_WIDTH_BITS-1:0] rd_data
);

	localparam int DEPTH = `TRACE_DEPTH;

	// Storage array, maps onto block RAM
	logic [`TRACE_WIDTH_BITS-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_enable)
			mem[wr_addr] <= wr_data;
	end

	// Read port, always enabled
	// Same address read and write returns the old word
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* hw/trace_top.sv */
/*
 * Trace buffer top level
 * Capture control and ring RAM feed the dump sequencer,
 * which drives the UART transmitter
 */

`include "trace_cfg.svh"

module trace_top (
	input clk,
	input reset,
	input [`TRACE_WIDTH_BITS-1:0] capture_data,
	input capture_enable,
	input trigger,
	output logic uart_tx,
	output logic dump_done
);

	// Capture to RAM
	logic wr_enable;
	logic [$clog2(`TRACE_DEPTH)-1:0] wr_addr;
	logic [`TRACE_WIDTH_BITS-1:0] wr_data;

	// Capture to sequencer
	logic dump_start;
	logic [$clog2(`TRACE_DEPTH)-1:0] oldest_addr;
	logic [$clog2(`TRACE_DEPTH):0] entry_count;

	// Sequencer and RAM read port
	logic [$clog2(`TRACE_DEPTH)-1:0] rd_addr;
	logic [`TRACE_WIDTH_BITS-1:0] rd_data;

	// Sequencer to transmitter
	logic tx_ready;
	logic tx_start;
	logic [7:0] tx_byte;

	trace_capture trace_capture_inst (
		.clk(clk),
		.reset(reset),
		.capture_data(capture_data),
		.capture_enable(capture_enable),
		.trigger(trigger),
		.wr_enable(wr_enable),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.dump_start(dump_start),
		.oldest_addr(oldest_addr),
		.entry_count(entry_count)
	);

	trace_ram trace_ram_inst (
		.clk(clk),
		.wr_enable(wr_enable),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	trace_dump_seq trace_dump_seq_inst (
		.clk(clk),
		.reset(reset),
		.dump_start(dump_start),
		.oldest_addr(oldest_addr),
		.entry_count(entry_count),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.tx_ready(tx_ready),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.dump_done(dump_done)
	);

	uart_tx uart_tx_inst (
		.clk(clk),
		.reset(reset),
		.tx_start(tx_start),
		.tx_byte(tx_byte),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx)
	);

endmodule

/* hw/uart_tx.sv */
/*
 * UART transmitter, 8N1, fixed baud divisor
 * A one-cycle tx_start in idle loads tx_byte and sends one frame
 * tx_ready is high only while idle
 */

`include "trace_cfg.svh"

module uart_tx import trace_pkg::*; (
	input clk,
	input reset,
	input tx_start,
	input [7:0] tx_byte,
	output logic tx_ready,
	output logic uart_tx
);

	localparam int BAUD_WIDTH = (`TRACE_BAUD_DIVIDE > 1) ? $clog2(`TRACE_BAUD_DIVIDE) : 1;

	uart_state_t state;
	logic [BAUD_WIDTH-1:0] baud_count;
	logic [2:0] bit_count;
	logic [7:0] shift_reg;
	logic bit_end;

	// Last clock of the current bit time
	assign bit_end = (baud_count == BAUD_WIDTH'(`TRACE_BAUD_DIVIDE - 1));

	assign tx_ready = (state == UART_IDLE);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= UART_IDLE;
			baud_count <= '0;
			bit_count <= '0;
			// Line idles high
			uart_tx <= 1'b1;
		end
		else
		begin
			// Bit timer runs in every state but idle
			if (state == UART_IDLE || bit_end)
				baud_count <= '0;
			else
				baud_count <= baud_count + 1'b1;

			case (state)
				UART_IDLE:
				begin
					if (tx_start)
					begin
						uart_tx <= 1'b0;
						state <= UART_START;
					end
				end

				UART_START:
				begin
					if (bit_end)
					begin
						// Data goes out LSB first
						uart_tx <= shift_reg[0];
						bit_count <= '0;
						state <= UART_DATA;
					end
				end

				UART_DATA:
				begin
					if (bit_end)
					begin
						if (bit_count == 3'd7)
						begin
							uart_tx <= 1'b1;
							state <= UART_STOP;
						end
						else
						begin
							// shift_reg moves on this same edge
							uart_tx <= shift_reg[1];
							bit_count <= bit_count + 1'b1;
						end
					end
				end

				UART_STOP:
				begin
					if (bit_end)
						state <= UART_IDLE;
				end
			endcase
		end
	end

	// Payload shifter
	always_ff @(posedge clk)
	begin
		if (state == UART_IDLE && tx_start)
			shift_reg <= tx_byte;
		else if (state == UART_DATA && bit_end)
			shift_reg <= shift_reg >> 1;
	end

endmodule

/* include/trace_cfg.svh */
/*
 * Build-time configuration of the trace buffer
 * Capture width, ring depth and UART bit time
 * Include this file wherever one of these values is needed
 */

`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Width in bits of one captured word
`define TRACE_WIDTH_BITS 32

// Ring entries, must be a power of two
// so the read and write pointers can wrap freely
`define TRACE_DEPTH 16

// Clock cycles per UART bit
`define TRACE_BAUD_DIVIDE 4

`endif

/* run_sim.sh */
#!/bin/sh
# Build the trace buffer testbench with Verilator and run it
# Exit status is zero only when the pass message appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module trace_tb -f flist.f -o trace_sim \
	|| { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/trace_sim)
echo "$sim_out"

echo "$sim_out" | grep -q "TESTS PASSED" && exit 0 || exit 1

/* testbench/trace_props.sv */
/*
 * Concurrent assertions for the trace buffer top level
 * Bound into trace_top, watches the idle line, the done flag,
 * the transmit handshake and the capture freeze
 */

module trace_props import trace_pkg::*; (
	input clk,
	input reset,
	input uart_tx,
	input dump_done,
	input tx_start,
	input tx_ready,
	input wr_enable,
	input dump_start
);

	// Set once the dump has been started, cleared only by reset
	logic dump_started;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			dump_started <= 1'b0;
		else if (dump_start)
			dump_started <= 1'b1;
	end

	// Line idles high through reset
	line_idle_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> uart_tx)
		else $error("uart_tx low while reset is held");

	// Done is sticky until reset
	done_sticky: assert property (@(posedge clk) disable iff (reset)
		$past(dump_done) |-> dump_done)
		else $error("dump_done fell without reset");

	// Transmitter only started when idle
	start_when_ready: assert property (@(posedge clk) disable iff (reset)
		tx_start |-> tx_ready)
		else $error("tx_start while transmitter busy");

	// No RAM write once frozen
	no_write_after_start: assert property (@(posedge clk) disable iff (reset)
		dump_started |-> !wr_enable)
		else $error("RAM written after dump start");

endmodule

bind trace_top trace_props trace_props_inst (
	.clk(clk),
	.reset(reset),
	.uart_tx(uart_tx),
	.dump_done(dump_done),
	.tx_start(tx_start),
	.tx_ready(tx_ready),
	.wr_enable(wr_enable),
	.dump_start(dump_start)
);

/* testbench/trace_tb.sv */
/*
 * Testbench for the trace buffer top level
 * Drives captures and triggers, decodes the UART line mid-bit and
 * compares every dumped byte with a reference model of the ring
 * Run from the project root with the file list
 */

`include "trace_cfg.svh"

module trace_tb;

	localparam int WORD_BYTES = `TRACE_WIDTH_BITS / 8;
	localparam int BIT_CYCLES = `TRACE_BAUD_DIVIDE;
	localparam int NUM_TESTS = 5;
	// Words dumped by the five tests in order
	localparam int TOTAL_BYTES = (5 + `TRACE_DEPTH + 6 + 0 + 6) * WORD_BYTES;
	localparam int WATCHDOG_CYCLES = 2 * (TOTAL_BYTES * 10 * BIT_CYCLES + NUM_TESTS * 200);

	typedef logic [`TRACE_WIDTH_BITS-1:0] word_q_t[$];
	typedef logic [7:0] byte_q_t[$];

	logic clk;
	logic reset;
	logic [`TRACE_WIDTH_BITS-1:0] capture_data;
	logic capture_enable;
	logic trigger;
	logic uart_tx;
	logic dump_done;

	integer seed = 76;
	int errors = 0;
	int errors_at_start = 0;
	int failed_tests = 0;
	int rx_count = 0;
	int kept = 0;
	logic triggered = 1'b0;
	// Every strobed word of the current test in strobe order
	word_q_t words;
	byte_q_t expected_q;
	byte_q_t rx_q;

	trace_top trace_top_inst (
		.clk(clk),
		.reset(reset),
		.capture_data(capture_data),
		.capture_enable(capture_enable),
		.trigger(trigger),
		.uart_tx(uart_tx),
		.dump_done(dump_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Expected dump of the last TRACE_DEPTH words up to the trigger
	// Oldest word first and each word least significant byte first
	function automatic byte_q_t expected_bytes(word_q_t strobed, int upto_trigger);
		byte_q_t bytes;
		int first;
		logic [`TRACE_WIDTH_BITS-1:0] word;
		first = (upto_trigger > `TRACE_DEPTH) ? upto_trigger - `TRACE_DEPTH : 0;
		for (int i = first; i < upto_trigger; i++)
		begin
			word = strobed[i];
			for (int b = 0; b < WORD_BYTES; b++)
				bytes.push_back(word[b*8 +: 8]);
		end
		return bytes;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	// One clock of stimulus with single-cycle strobes
	task automatic drive_cycle(input logic strobe, input logic trig);
		logic [`TRACE_WIDTH_BITS-1:0] data;
		data = $random(seed);
		@(posedge clk);
		capture_data <= data;
		capture_enable <= strobe;
		trigger <= trig;
		if (strobe)
			words.push_back(data);
		// Only the first trigger freezes the model
		if (trig && !triggered)
		begin
			triggered = 1'b1;
			kept = words.size();
			expected_q = expected_bytes(words, kept);
		end
	endtask

	task automatic start_test();
		@(posedge clk);
		reset <= 1'b1;
		capture_enable <= 1'b0;
		trigger <= 1'b0;
		words.delete();
		expected_q.delete();
		rx_q.delete();
		triggered = 1'b0;
		kept = 0;
		rx_count = 0;
		errors_at_start = errors;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic finish_test(input int num, input string name);
		do
			@(negedge clk);
		while (dump_done !== 1'b1);
		// Longer than one frame so a stray frame after done is still decoded here
		repeat (12 * BIT_CYCLES) @(negedge clk);
		if (expected_q.size() != 0)
		begin
			$display("test %0d: %0d expected bytes never arrived", num, expected_q.size());
			errors++;
		end
		if (errors == errors_at_start)
			$display("test %0d %s: ok, %0d bytes", num, name, rx_count);
		else
		begin
			$display("test %0d %s: failed, %0d bytes, %0d errors", num, name, rx_count,
				errors - errors_at_start);
			failed_tests++;
		end
	endtask

	// UART decoder that samples near the middle of each bit on the falling clock
	initial
	begin : uart_decoder
		logic [7:0] rx;
		@(negedge reset);
		forever
		begin
			@(negedge uart_tx);
			if (reset)
				continue;
			repeat (BIT_CYCLES / 2) @(negedge clk);
			check_value("uart_start_bit", 32'd0, 32'(uart_tx));
			for (int i = 0; i < 8; i++)
			begin
				repeat (BIT_CYCLES) @(negedge clk);
				rx[i] = uart_tx;
			end
			repeat (BIT_CYCLES) @(negedge clk);
			check_value("uart_stop_bit", 32'd1, 32'(uart_tx));
			rx_q.push_back(rx);
			rx_count++;
		end
	end

	// Pairs each decoded byte with the next expected one
	initial
	begin : compare_bytes
		logic [7:0] got;
		logic [7:0] want;
		forever
		begin
			@(negedge clk);
			while (rx_q.size() > 0)
			begin
				got = rx_q.pop_front();
				if (expected_q.size() == 0)
				begin
					$display("byte 0x%0h arrived when no more bytes were expected", got);
					errors++;
				end
				else
				begin
					want = expected_q.pop_front();
					check_value("uart_byte", 32'(want), 32'(got));
				end
			end
		end
	end

	initial
	begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, dump never finished", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin : main
		reset = 1'b1;
		capture_data = '0;
		capture_enable = 1'b0;
		trigger = 1'b0;

		// Partial fill with the trigger alone
		start_test();
		repeat (5) drive_cycle(1'b1, 1'b0);
		drive_cycle(1'b0, 1'b1);
		drive_cycle(1'b0, 1'b0);
		finish_test(1, "partial fill");

		// More words than slots with random gaps between strobes
		start_test();
		for (int i = 0; i < `TRACE_DEPTH + 7; i++)
		begin
			drive_cycle(1'b1, 1'b0);
			if (($random(seed) & 3) == 0)
				drive_cycle(1'b0, 1'b0);
		end
		drive_cycle(1'b0, 1'b1);
		drive_cycle(1'b0, 1'b0);
		finish_test(2, "wraparound");

		// Word in the trigger cycle is kept
		start_test();
		repeat (5) drive_cycle(1'b1, 1'b0);
		drive_cycle(1'b1, 1'b1);
		// Strobes during the dump and a second trigger
		for (int i = 0; i < 12; i++)
			drive_cycle(1'b1, i == 6);
		drive_cycle(1'b0, 1'b0);
		finish_test(3, "trigger cycle and freeze");

		// Nothing captured
		start_test();
		drive_cycle(1'b0, 1'b1);
		drive_cycle(1'b0, 1'b0);
		finish_test(4, "empty dump");

		// Line idles high and done stays low until the trigger
		start_test();
		for (int i = 0; i < 12; i++)
		begin
			drive_cycle(i[0], 1'b0);
			@(negedge clk);
			check_value("uart_tx", 32'd1, 32'(uart_tx));
			check_value("dump_done", 32'd0, 32'(dump_done));
		end
		drive_cycle(1'b0, 1'b1);
		drive_cycle(1'b0, 1'b0);
		finish_test(5, "framing and idle");

		$display("%0d of %0d tests failed, %0d errors", failed_tests, NUM_TESTS, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
